//--- src/tomasulo_params.svh
`ifndef TOMASULO_PARAMS_SVH
`define TOMASULO_PARAMS_SVH

// data path and pc width
`define DATA_W 32

// rename tag width
`define TAG_W 6

// tags held by the free list
`define NUM_TAGS 16

// fetch queue entries
`define IFQ_DEPTH 8

// architectural register address width
`define REG_ADDR_W 5

`endif

//--- src/tomasulo_pkg.sv
`include "tomasulo_params.svh"

package tomasulo_pkg;

   // rename tag handed out by the free list
   typedef logic [`TAG_W-1:0] tag_t;

   // primary opcode field, inst[31:26]
   typedef enum logic [5:0] {
      RTYPE = 6'b000000,
      J     = 6'b000010,
      BEQ   = 6'b000100,
      LW    = 6'b100011,
      SW    = 6'b101011
   } opcode_e;

   // one fetch queue slot
   typedef struct packed {
      logic [`DATA_W-1:0] pc;
      logic [`DATA_W-1:0] inst;
   } ifq_entry_t;

   // source operand as sent to an issue queue
   // tag only meaningful while ready is low
   typedef struct packed {
      logic [`DATA_W-1:0] data;
      logic               ready;
      tag_t               tag;
   } operand_t;

endpackage

//--- src/sync_fifo.sv
`timescale 1ns/100ps

module sync_fifo #(
   parameter type payload_t = logic [7:0],
   parameter int  DEPTH     = 8
) (
   input  logic     clk,
   input  logic     reset,

   input  logic     wr_en,
   input  payload_t wr_data,
   output logic     full,

   input  logic     rd_en,
   output payload_t rd_data,
   output logic     empty
);

   localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CNT_W = $clog2(DEPTH + 1);

   payload_t         mem [DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [CNT_W-1:0] count;
   logic             do_wr;
   logic             do_rd;

   assign full  = (count == CNT_W'(DEPTH));
   assign empty = (count == '0);

   // requests beyond the limits are ignored
   assign do_wr = wr_en && !full;
   assign do_rd = rd_en && !empty;

   // head shows without a read
   assign rd_data = mem[rd_ptr];

   always_ff @(posedge clk) begin
      if (reset) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_wr)
            wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         if (do_rd)
            rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         // push and pop together leave the count alone
         case ({do_wr, do_rd})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (do_wr)
         mem[wr_ptr] <= wr_data;
   end

endmodule

//--- src/tag_free_list.sv
`timescale 1ns/100ps
`include "tomasulo_params.svh"

module tag_free_list (
   input  logic               clk,
   input  logic               reset,

   input  logic               alloc,
   output tomasulo_pkg::tag_t alloc_tag,
   output logic               tag_avail,

   input  logic               release_valid,
   input  tomasulo_pkg::tag_t release_tag
);

   localparam tomasulo_pkg::tag_t LAST_TAG = tomasulo_pkg::tag_t'(`NUM_TAGS - 1);

   tomasulo_pkg::tag_t init_cnt;
   logic               init_done;
   logic               push;
   tomasulo_pkg::tag_t push_tag;
   logic               fifo_empty;

   // fill with 0 .. NUM_TAGS-1 once after reset
   always_ff @(posedge clk) begin
      if (reset) begin
         init_cnt  <= '0;
         init_done <= 1'b0;
      end else if (!init_done) begin
         init_cnt <= init_cnt + 1'b1;
         if (init_cnt == LAST_TAG)
            init_done <= 1'b1;
      end
   end

   // init fill owns the push side until done
   // afterwards tags come back from the CDB in broadcast order
   assign push     = !init_done || release_valid;
   assign push_tag = init_done ? release_tag : init_cnt;

   // list reads as empty while filling
   assign tag_avail = init_done && !fifo_empty;

   sync_fifo #(
      .payload_t(tomasulo_pkg::tag_t),
      .DEPTH    (`NUM_TAGS          )
   ) tag_fifo (
      .clk    (clk                  ),
      .reset  (reset                ),
      .wr_en  (push                 ),
      .wr_data(push_tag             ),
      .full   (                     ),
      .rd_en  (alloc && tag_avail   ),
      .rd_data(alloc_tag            ),
      .empty  (fifo_empty           )
   );

endmodule

//--- src/regfile.sv
`timescale 1ns/100ps
`include "tomasulo_params.svh"

module regfile (
   input  logic                   clk,
   input  logic                   reset,

   // write side, one bit per register from the status table
   input  logic [`DATA_W-1:0]     cdb_wdata,
   input  logic [31:0]            wen_onehot,

   input  logic [`REG_ADDR_W-1:0] rs_addr,
   input  logic [`REG_ADDR_W-1:0] rt_addr,
   input  logic [`REG_ADDR_W-1:0] debug_addr,
   output logic [`DATA_W-1:0]     rs_data,
   output logic [`DATA_W-1:0]     rt_data,
   output logic [`DATA_W-1:0]     debug_data
);

   logic [`DATA_W-1:0] regs [32];

   always_ff @(posedge clk) begin
      if (reset) begin
         for (int i = 0; i < 32; i++)
            regs[i] <= '0;
      end else begin
         // r0 stays zero
         for (int i = 1; i < 32; i++) begin
            if (wen_onehot[i])
               regs[i] <= cdb_wdata;
         end
      end
   end

   // combinational reads
   assign rs_data    = regs[rs_addr];
   assign rt_data    = regs[rt_addr];
   assign debug_data = regs[debug_addr];

endmodule

//--- src/reg_status_table.sv
`timescale 1ns/100ps
`include "tomasulo_params.svh"

module reg_status_table (
   input  logic                   clk,
   input  logic                   reset,

   // rename from dispatch
   input  logic                   rename_wen,
   input  logic [`REG_ADDR_W-1:0] rename_addr,
   input  tomasulo_pkg::tag_t     rename_tag,

   // CDB snoop
   input  logic                   cdb_valid,
   input  tomasulo_pkg::tag_t     cdb_tag,
   output logic [31:0]            regfile_wen_onehot,

   // source lookups
   input  logic [`REG_ADDR_W-1:0] rs_addr,
   input  logic [`REG_ADDR_W-1:0] rt_addr,
   output tomasulo_pkg::tag_t     rs_tag,
   output tomasulo_pkg::tag_t     rt_tag,
   output logic                   rs_busy,
   output logic                   rt_busy
);

   logic [31:0]        busy;
   tomasulo_pkg::tag_t tags [32];

   // every busy entry waiting on the broadcast tag
   always_comb begin
      for (int i = 0; i < 32; i++)
         regfile_wen_onehot[i] = cdb_valid && busy[i] && (tags[i] == cdb_tag);
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         busy <= '0;
      end else begin
         for (int i = 1; i < 32; i++) begin
            // new rename beats a same-cycle clear
            if (rename_wen && (int'(rename_addr) == i))
               busy[i] <= 1'b1;
            else if (regfile_wen_onehot[i])
               busy[i] <= 1'b0;
         end
      end
   end

   // r0 never renamed
   always_ff @(posedge clk) begin
      if (rename_wen && (rename_addr != '0))
         tags[rename_addr] <= rename_tag;
   end

   assign rs_busy = busy[rs_addr];
   assign rt_busy = busy[rt_addr];
   assign rs_tag  = tags[rs_addr];
   assign rt_tag  = tags[rt_addr];

endmodule

//--- src/dispatch.sv
`timescale 1ns/100ps
`include "tomasulo_params.svh"

module dispatch (
   input  logic                       clk,
   input  logic                       reset,

   // fetch queue head
   input  tomasulo_pkg::ifq_entry_t   ifq_head,
   input  logic                       ifq_empty,
   output logic                       ifq_rd_en,

   // CDB
   input  logic                       cdb_valid,
   input  logic                       cdb_branch,
   input  logic                       cdb_branch_taken,
   input  tomasulo_pkg::tag_t         cdb_tag,
   input  logic [`DATA_W-1:0]         cdb_data,

   // issue ports
   output logic                       issue_int_en,
   output logic                       issue_ldst_en,
   input  logic                       issue_int_full,
   input  logic                       issue_ldst_full,
   output logic [5:0]                 issue_int_opcode,
   output tomasulo_pkg::opcode_e      issue_ldst_opcode,
   output logic [`DATA_W-1:0]         issue_ldst_imm,
   output tomasulo_pkg::operand_t     issue_rs,
   output tomasulo_pkg::operand_t     issue_rt,
   output tomasulo_pkg::tag_t         issue_rd_tag,

   // redirect to fetch
   output logic                       redirect_valid,
   output logic [`DATA_W-1:0]         redirect_addr,

   input  logic [`REG_ADDR_W-1:0]     debug_addr,
   output logic [`DATA_W-1:0]         debug_data
);

   typedef enum logic [1:0] {S_NORMAL, S_BRANCH, S_DISCARD} state_e;

   state_e                 state;
   tomasulo_pkg::tag_t     pend_tag;
   logic [`DATA_W-1:0]     target;

   logic [`DATA_W-1:0]     inst;
   tomasulo_pkg::opcode_e  opcode;
   logic [`REG_ADDR_W-1:0] rs_addr;
   logic [`REG_ADDR_W-1:0] rt_addr;
   logic [`REG_ADDR_W-1:0] dest_addr;
   logic [`DATA_W-1:0]     imm_sext;
   logic [`DATA_W-1:0]     pc_plus4;
   logic [`DATA_W-1:0]     br_target;
   logic [`DATA_W-1:0]     j_target;
   logic                   is_rtype, is_lw, is_sw, is_beq, is_j;
   logic                   to_int, to_ldst, has_dest, needs_tag;
   logic                   head_ok, port_ok, discard_pop;
   logic                   issue_go, jump_go, drop_go, branch_resolve;

   logic [`DATA_W-1:0]     rf_rs_data;
   logic [`DATA_W-1:0]     rf_rt_data;
   logic [31:0]            wen_onehot;
   tomasulo_pkg::tag_t     rs_tag;
   tomasulo_pkg::tag_t     rt_tag;
   logic                   rs_busy;
   logic                   rt_busy;
   tomasulo_pkg::tag_t     alloc_tag;
   logic                   tag_avail;
   tomasulo_pkg::operand_t rs_op;
   tomasulo_pkg::operand_t rt_op;

   // ready from regfile, ready by CDB forward, or waiting on tag
   function automatic tomasulo_pkg::operand_t lookup_operand(
      input logic                   busy,
      input tomasulo_pkg::tag_t     tag,
      input logic [`DATA_W-1:0]     rf_data,
      input logic                   fwd_valid,
      input tomasulo_pkg::tag_t     fwd_tag,
      input logic [`DATA_W-1:0]     fwd_data
   );
      tomasulo_pkg::operand_t op;
      op = '0;
      if (!busy) begin
         op.data  = rf_data;
         op.ready = 1'b1;
      end else if (fwd_valid && (fwd_tag == tag)) begin
         op.data  = fwd_data;
         op.ready = 1'b1;
      end else begin
         op.tag = tag;
      end
      return op;
   endfunction

   // decode of the head instruction
   assign inst      = ifq_head.inst;
   assign opcode    = tomasulo_pkg::opcode_e'(inst[31:26]);
   assign rs_addr   = inst[25:21];
   assign rt_addr   = inst[20:16];
   assign is_rtype  = (opcode == tomasulo_pkg::RTYPE);
   assign is_lw     = (opcode == tomasulo_pkg::LW);
   assign is_sw     = (opcode == tomasulo_pkg::SW);
   assign is_beq    = (opcode == tomasulo_pkg::BEQ);
   assign is_j      = (opcode == tomasulo_pkg::J);
   assign to_int    = is_rtype || is_beq;
   assign to_ldst   = is_lw || is_sw;
   // rd for R-type, rt for LW
   assign has_dest  = is_rtype || is_lw;
   assign dest_addr = is_rtype ? inst[15:11] : rt_addr;
   // BEQ carries a tag for its resolve broadcast
   assign needs_tag = has_dest || is_beq;

   assign imm_sext  = {{16{inst[15]}}, inst[15:0]};
   assign pc_plus4  = ifq_head.pc + 32'd4;
   assign br_target = pc_plus4 + {imm_sext[29:0], 2'b00};
   assign j_target  = {pc_plus4[31:28], inst[25:0], 2'b00};

   // discard ends once the head is the redirect target
   assign head_ok = !ifq_empty &&
                    ((state == S_NORMAL) ||
                     ((state == S_DISCARD) && (ifq_head.pc == target)));
   assign discard_pop = (state == S_DISCARD) && !ifq_empty && (ifq_head.pc != target);

   assign port_ok  = (to_int && !issue_int_full) || (to_ldst && !issue_ldst_full);
   assign issue_go = head_ok && port_ok && (!needs_tag || tag_avail);
   assign jump_go  = head_ok && is_j;
   // unknown opcodes leave the queue unissued
   assign drop_go  = head_ok && !to_int && !to_ldst && !is_j;

   assign ifq_rd_en = issue_go || jump_go || drop_go || discard_pop;

   assign branch_resolve = (state == S_BRANCH) && cdb_valid && cdb_branch &&
                           (cdb_tag == pend_tag);

   assign rs_op = lookup_operand(rs_busy, rs_tag, rf_rs_data, cdb_valid, cdb_tag, cdb_data);
   assign rt_op = lookup_operand(rt_busy, rt_tag, rf_rt_data, cdb_valid, cdb_tag, cdb_data);

   // target register holds the address until the redirect pulse
   assign redirect_addr = target;

   always_ff @(posedge clk) begin
      if (reset) begin
         state          <= S_NORMAL;
         redirect_valid <= 1'b0;
      end else begin
         redirect_valid <= 1'b0;
         case (state)
            S_BRANCH: begin
               if (branch_resolve) begin
                  redirect_valid <= cdb_branch_taken;
                  state          <= cdb_branch_taken ? S_DISCARD : S_NORMAL;
               end
            end
            default: begin
               if (jump_go) begin
                  redirect_valid <= 1'b1;
                  state          <= S_DISCARD;
               end else if (issue_go && is_beq) begin
                  state <= S_BRANCH;
               end else if (issue_go || drop_go) begin
                  state <= S_NORMAL;
               end
            end
         endcase
      end
   end

   // jump and branch targets, pending branch tag
   always_ff @(posedge clk) begin
      if (jump_go) begin
         target <= j_target;
      end else if (issue_go && is_beq) begin
         target   <= br_target;
         pend_tag <= alloc_tag;
      end
   end

   // issue enables, one-cycle pulses
   always_ff @(posedge clk) begin
      if (reset) begin
         issue_int_en  <= 1'b0;
         issue_ldst_en <= 1'b0;
      end else begin
         issue_int_en  <= issue_go && to_int;
         issue_ldst_en <= issue_go && to_ldst;
      end
   end

   // issue payload
   always_ff @(posedge clk) begin
      if (issue_go) begin
         // func field for R-type, primary opcode for BEQ
         issue_int_opcode  <= is_rtype ? inst[5:0] : inst[31:26];
         issue_ldst_opcode <= opcode;
         issue_ldst_imm    <= imm_sext;
         issue_rs          <= rs_op;
         issue_rt          <= rt_op;
         issue_rd_tag      <= needs_tag ? alloc_tag : '0;
      end
   end

   regfile regfile (
      .clk       (clk       ),
      .reset     (reset     ),
      .cdb_wdata (cdb_data  ),
      .wen_onehot(wen_onehot),
      .rs_addr   (rs_addr   ),
      .rt_addr   (rt_addr   ),
      .debug_addr(debug_addr),
      .rs_data   (rf_rs_data),
      .rt_data   (rf_rt_data),
      .debug_data(debug_data)
   );

   // r0 never renamed
   reg_status_table reg_status_table (
      .clk               (clk                                          ),
      .reset             (reset                                        ),
      .rename_wen        (issue_go && has_dest && (dest_addr != '0)    ),
      .rename_addr       (dest_addr                                    ),
      .rename_tag        (alloc_tag                                    ),
      .cdb_valid         (cdb_valid                                    ),
      .cdb_tag           (cdb_tag                                      ),
      .regfile_wen_onehot(wen_onehot                                   ),
      .rs_addr           (rs_addr                                      ),
      .rt_addr           (rt_addr                                      ),
      .rs_tag            (rs_tag                                       ),
      .rt_tag            (rt_tag                                       ),
      .rs_busy           (rs_busy                                      ),
      .rt_busy           (rt_busy                                      )
   );

   // every CDB broadcast returns its tag
   tag_free_list tag_free_list (
      .clk          (clk                    ),
      .reset        (reset                  ),
      .alloc        (issue_go && needs_tag  ),
      .alloc_tag    (alloc_tag              ),
      .tag_avail    (tag_avail              ),
      .release_valid(cdb_valid              ),
      .release_tag  (cdb_tag                )
   );

endmodule

//--- src/dispatch_top.sv
`timescale 1ns/100ps
`include "tomasulo_params.svh"

module dispatch_top (
   input  logic                   clk,
   input  logic                   reset,

   // fetch side
   input  logic                   ifq_wr_en,
   input  logic [`DATA_W-1:0]     ifq_wr_pc,
   input  logic [`DATA_W-1:0]     ifq_wr_inst,
   output logic                   ifq_full,

   // CDB
   input  logic                   cdb_valid,
   input  tomasulo_pkg::tag_t     cdb_tag,
   input  logic [`DATA_W-1:0]     cdb_data,
   input  logic                   cdb_branch,
   input  logic                   cdb_branch_taken,

   // issue ports
   output logic                   issue_int_en,
   output logic [5:0]             issue_int_opcode,
   input  logic                   issue_int_full,
   output logic                   issue_ldst_en,
   output tomasulo_pkg::opcode_e  issue_ldst_opcode,
   output logic [`DATA_W-1:0]     issue_ldst_imm,
   input  logic                   issue_ldst_full,
   output tomasulo_pkg::operand_t issue_rs,
   output tomasulo_pkg::operand_t issue_rt,
   output tomasulo_pkg::tag_t     issue_rd_tag,

   output logic                   redirect_valid,
   output logic [`DATA_W-1:0]     redirect_addr,

   input  logic [`REG_ADDR_W-1:0] debug_addr,
   output logic [`DATA_W-1:0]     debug_data
);

   tomasulo_pkg::ifq_entry_t ifq_wr_data;
   tomasulo_pkg::ifq_entry_t ifq_head;
   logic                     ifq_empty;
   logic                     ifq_rd_en;

   // pc and word packed into one queue slot
   assign ifq_wr_data = '{pc: ifq_wr_pc, inst: ifq_wr_inst};

   sync_fifo #(
      .payload_t(tomasulo_pkg::ifq_entry_t),
      .DEPTH    (`IFQ_DEPTH               )
   ) ifq (
      .clk    (clk        ),
      .reset  (reset      ),
      .wr_en  (ifq_wr_en  ),
      .wr_data(ifq_wr_data),
      .full   (ifq_full   ),
      .rd_en  (ifq_rd_en  ),
      .rd_data(ifq_head   ),
      .empty  (ifq_empty  )
   );

   dispatch dispatch (
      .clk              (clk              ),
      .reset            (reset            ),
      .ifq_head         (ifq_head         ),
      .ifq_empty        (ifq_empty        ),
      .ifq_rd_en        (ifq_rd_en        ),
      .cdb_valid        (cdb_valid        ),
      .cdb_branch       (cdb_branch       ),
      .cdb_branch_taken (cdb_branch_taken ),
      .cdb_tag          (cdb_tag          ),
      .cdb_data         (cdb_data         ),
      .issue_int_en     (issue_int_en     ),
      .issue_ldst_en    (issue_ldst_en    ),
      .issue_int_full   (issue_int_full   ),
      .issue_ldst_full  (issue_ldst_full  ),
      .issue_int_opcode (issue_int_opcode ),
      .issue_ldst_opcode(issue_ldst_opcode),
      .issue_ldst_imm   (issue_ldst_imm   ),
      .issue_rs         (issue_rs         ),
      .issue_rt         (issue_rt         ),
      .issue_rd_tag     (issue_rd_tag     ),
      .redirect_valid   (redirect_valid   ),
      .redirect_addr    (redirect_addr    ),
      .debug_addr       (debug_addr       ),
      .debug_data       (debug_data       )
   );

endmodule

//--- dv/tb_clock_gen.sv
`timescale 1ns/100ps

module tb_clock_gen (
   output logic clk,
   output logic reset
);

   // 100 ns period
   initial clk = 1'b0;
   always #50 clk = ~clk;

   // reset over the first 10 edges, dropped just after an edge
   initial begin
      reset = 1'b1;
      repeat (10) @(posedge clk);
      #10 reset = 1'b0;
   end

endmodule

//--- dv/dispatch_tb.sv
`timescale 1ns/100ps
`include "tomasulo_params.svh"

module dispatch_tb;

   // one captured output event
   // kind is 0 for int issue, 1 for ldst issue, 2 for redirect
   typedef struct packed {
      logic [1:0]             kind;
      logic [5:0]             opcode;
      logic [31:0]            imm;
      tomasulo_pkg::operand_t rs;
      tomasulo_pkg::operand_t rt;
      tomasulo_pkg::tag_t     rd_tag;
      logic [31:0]            addr;
   } event_t;

   logic clk, reset;
   logic ifq_wr_en, ifq_full;
   logic [31:0] ifq_wr_pc, ifq_wr_inst;
   logic cdb_valid, cdb_branch, cdb_branch_taken;
   tomasulo_pkg::tag_t cdb_tag;
   logic [31:0] cdb_data;
   logic issue_int_en, issue_int_full, issue_ldst_en, issue_ldst_full;
   logic [5:0] issue_int_opcode;
   tomasulo_pkg::opcode_e issue_ldst_opcode;
   logic [31:0] issue_ldst_imm;
   tomasulo_pkg::operand_t issue_rs, issue_rt;
   tomasulo_pkg::tag_t issue_rd_tag;
   logic redirect_valid;
   logic [31:0] redirect_addr;
   logic [4:0] debug_addr;
   logic [31:0] debug_data;

   event_t events[$];
   event_t ev;
   int fd;
   string line;
   byte kind;
   logic [31:0] v0, v1, v2, v3, v4, v5, v6, v7, v8, v9;

   tb_clock_gen clock_gen (.clk(clk), .reset(reset));

   dispatch_top DUT (.*);

   task automatic stop_on_failure();
      $display("TEST FAILED");
      $fatal(1);
   endtask

   // inputs move 10 ns after the rising edge
   task automatic step();
      @(posedge clk);
      #10;
   endtask

   task automatic wait_reset_release();
      int n;
      n = 0;
      while (reset !== 1'b0) begin
         if (n == 200) begin
            $display("reset still asserted after 200 cycles");
            stop_on_failure();
         end
         @(posedge clk);
         n++;
      end
   endtask

   task automatic check_data(string what, logic [31:0] got, logic [31:0] exp);
      if (got !== exp) begin
         $display("MISMATCH at %0t: %s got %h expected %h", $time, what, got, exp);
         stop_on_failure();
      end
   endtask

   task automatic check_tag(string what, tomasulo_pkg::tag_t got, tomasulo_pkg::tag_t exp);
      if (got !== exp) begin
         $display("MISMATCH at %0t: %s tag got %0d expected %0d", $time, what, got, exp);
         stop_on_failure();
      end
   endtask

   task automatic check_opcode(string what, tomasulo_pkg::opcode_e got,
                               tomasulo_pkg::opcode_e exp);
      if (got !== exp) begin
         $display("MISMATCH at %0t: %s opcode got %h expected %h", $time, what, got, exp);
         stop_on_failure();
      end
   endtask

   // data counts only when ready, tag only when waiting
   task automatic check_operand(string what, tomasulo_pkg::operand_t got,
                                tomasulo_pkg::operand_t exp);
      if ((got.ready !== exp.ready) || (exp.ready && (got.data !== exp.data)) ||
          (!exp.ready && (got.tag !== exp.tag))) begin
         $display("MISMATCH at %0t: %s got rdy %b data %h tag %0d, expected rdy %b data %h tag %0d",
                  $time, what, got.ready, got.data, got.tag, exp.ready, exp.data, exp.tag);
         stop_on_failure();
      end
   endtask

   function automatic tomasulo_pkg::operand_t make_operand(logic [31:0] rdy,
                                                           logic [31:0] data,
                                                           logic [31:0] tag);
      tomasulo_pkg::operand_t op;
      op.ready = rdy[0];
      op.data  = data;
      op.tag   = tomasulo_pkg::tag_t'(tag);
      return op;
   endfunction

   // outputs settle mid-cycle
   always @(negedge clk) begin : capture_events
      event_t e;
      if (!reset) begin
         if (issue_int_en) begin
            e = '{kind: 2'd0, opcode: issue_int_opcode, imm: '0, rs: issue_rs,
                  rt: issue_rt, rd_tag: issue_rd_tag, addr: '0};
            events.push_back(e);
         end
         if (issue_ldst_en) begin
            e = '{kind: 2'd1, opcode: issue_ldst_opcode, imm: issue_ldst_imm, rs: issue_rs,
                  rt: issue_rt, rd_tag: issue_rd_tag, addr: '0};
            events.push_back(e);
         end
         if (redirect_valid) begin
            e = '{kind: 2'd2, opcode: '0, imm: '0, rs: '0, rt: '0, rd_tag: '0,
                  addr: redirect_addr};
            events.push_back(e);
         end
      end
   end

   task automatic fetch_write(logic [31:0] pc, logic [31:0] inst);
      int n;
      n = 0;
      while (ifq_full) begin
         if (n == 200) begin
            $display("fetch queue stayed full for 200 cycles");
            stop_on_failure();
         end
         step();
         n++;
      end
      ifq_wr_en   = 1'b1;
      ifq_wr_pc   = pc;
      ifq_wr_inst = inst;
      step();
      ifq_wr_en = 1'b0;
   endtask

   // optional drop of int full in the broadcast cycle
   task automatic cdb_broadcast(logic [31:0] tag, logic [31:0] data, logic br,
                                logic taken, logic unfull);
      cdb_valid        = 1'b1;
      cdb_tag          = tomasulo_pkg::tag_t'(tag);
      cdb_data         = data;
      cdb_branch       = br;
      cdb_branch_taken = taken;
      if (unfull)
         issue_int_full = 1'b0;
      step();
      cdb_valid        = 1'b0;
      cdb_branch       = 1'b0;
      cdb_branch_taken = 1'b0;
   endtask

   task automatic next_event(logic [1:0] want, output event_t e);
      int n;
      n = 0;
      while (events.size() == 0) begin
         if (n == 200) begin
            $display("no issue or redirect within 200 cycles at %0t", $time);
            stop_on_failure();
         end
         step();
         n++;
      end
      e = events.pop_front();
      if (e.kind != want) begin
         $display("MISMATCH at %0t: event kind %0d expected %0d", $time, e.kind, want);
         stop_on_failure();
      end
   endtask

   task automatic idle_no_events(int cycles);
      repeat (cycles) step();
      if (events.size() != 0) begin
         $display("an issue or redirect appeared while dispatch should stall");
         stop_on_failure();
      end
   endtask

   initial begin
      ifq_wr_en        = 1'b0;
      ifq_wr_pc        = '0;
      ifq_wr_inst      = '0;
      cdb_valid        = 1'b0;
      cdb_tag          = '0;
      cdb_data         = '0;
      cdb_branch       = 1'b0;
      cdb_branch_taken = 1'b0;
      issue_int_full   = 1'b0;
      issue_ldst_full  = 1'b0;
      debug_addr       = '0;
      void'($urandom(32'h00b3_3d05));

      fd = $fopen("dv/dispatch_stim.txt", "r");
      if (fd == 0) begin
         $display("cannot open dv/dispatch_stim.txt");
         stop_on_failure();
      end
      wait_reset_release();
      step();

      // queue not full and no pulses once out of reset
      check_data("ifq_full after reset", 32'(ifq_full), 32'd0);
      check_data("redirect after reset", 32'(redirect_valid), 32'd0);
      check_data("int issue after reset", 32'(issue_int_en), 32'd0);
      check_data("ldst issue after reset", 32'(issue_ldst_en), 32'd0);

      while ($fgets(line, fd) != 0) begin
         if ((line.len() < 2) || (line[0] == "#"))
            continue;
         void'($sscanf(line, "%c", kind));
         // short idle gap between records
         repeat ($urandom_range(3, 0)) step();
         case (kind)
            "W": begin
               // free list fill takes NUM_TAGS cycles
               repeat (`NUM_TAGS + 4) step();
            end
            "F": begin
               void'($sscanf(line, "%c %h %h", kind, v0, v1));
               fetch_write(v0, v1);
            end
            "C": begin
               void'($sscanf(line, "%c %h %h %h %h %h", kind, v0, v1, v2, v3, v4));
               cdb_broadcast(v0, v1, v2[0], v3[0], v4[0]);
            end
            "Q": begin
               void'($sscanf(line, "%c %h %h", kind, v0, v1));
               if (v0 == 0)
                  issue_int_full = v1[0];
               else
                  issue_ldst_full = v1[0];
            end
            "X": begin
               void'($sscanf(line, "%c %d", kind, v0));
               idle_no_events(v0);
            end
            "I": begin
               void'($sscanf(line, "%c %h %h %h %h %h %h %h %h",
                             kind, v0, v1, v2, v3, v4, v5, v6, v7));
               next_event(2'd0, ev);
               check_data("int opcode", 32'(ev.opcode), v0);
               check_operand("int rs", ev.rs, make_operand(v1, v2, v3));
               check_operand("int rt", ev.rt, make_operand(v4, v5, v6));
               check_tag("int rd", ev.rd_tag, tomasulo_pkg::tag_t'(v7));
            end
            "L": begin
               void'($sscanf(line, "%c %h %h %h %h %h %h %h %h %h %h",
                             kind, v0, v1, v2, v3, v4, v5, v6, v7, v8, v9));
               next_event(2'd1, ev);
               check_opcode("ldst", tomasulo_pkg::opcode_e'(ev.opcode),
                            tomasulo_pkg::opcode_e'(v0[5:0]));
               check_data("ldst imm", ev.imm, v1);
               check_operand("ldst rs", ev.rs, make_operand(v2, v3, v4));
               check_operand("ldst rt", ev.rt, make_operand(v5, v6, v7));
               // stores carry no destination tag
               if (v8[0])
                  check_tag("ldst rd", ev.rd_tag, tomasulo_pkg::tag_t'(v9));
            end
            "R": begin
               void'($sscanf(line, "%c %h", kind, v0));
               next_event(2'd2, ev);
               check_data("redirect addr", ev.addr, v0);
            end
            "D": begin
               void'($sscanf(line, "%c %h %h", kind, v0, v1));
               debug_addr = v0[4:0];
               @(negedge clk);
               check_data("debug read", debug_data, v1);
               step();
            end
            default: begin
               $display("unknown record kind in stim file: %s", line);
               stop_on_failure();
            end
         endcase
      end
      $fclose(fd);

      repeat (5) step();
      if (events.size() != 0) begin
         $display("issue or redirect left over with no matching record");
         $display("TEST FAILED");
         $fatal(1);
      end else begin
         $display("TEST OK");
         $finish;
      end
   end

endmodule

//--- sim.f
+incdir+src
src/tomasulo_pkg.sv
src/sync_fifo.sv
src/tag_free_list.sv
src/regfile.sv
src/reg_status_table.sv
src/dispatch.sv
src/dispatch_top.sv
dv/tb_clock_gen.sv
dv/dispatch_tb.sv

//--- dv/dispatch_stim.txt
# F pc inst | C tag data br taken unfull | Q port(0 int,1 ldst) full | X cycles | W
# I op rsrdy rsdata rstag rtrdy rtdata rttag rdtag | L op imm rs.. rt.. hastag rdtag | R addr | D reg data
W
F 100 00221820
I 20 1 0 0 1 0 0 0
C 0 11111111 0 0 0
D 3 11111111
F 104 00222820
F 108 00a33020
I 20 1 0 0 1 0 0 1
I 20 0 0 1 1 11111111 0 2
Q 0 1
F 10c 00c53820
X 5
C 2 22222222 0 0 1
I 20 1 22222222 0 0 0 1 3
C 1 33333333 0 0 0
D 5 33333333
D 6 22222222
F 110 8c68fffc
L 23 fffffffc 1 11111111 0 1 0 0 1 4
F 114 aca60008
L 2b 00000008 1 33333333 0 1 22222222 0 0 0
F 118 01004820
I 20 0 0 4 1 0 0 5
Q 0 1
F 11c 00225020
F 120 ac010000
X 6
Q 0 0
I 20 1 0 0 1 0 0 6
L 2b 00000000 1 0 0 1 0 0 0 0
F 124 10220003
I 04 1 0 0 1 0 0 7
F 128 00225820
F 12c 00226020
F 130 00226820
F 134 00227020
X 5
C 7 0 1 1 0
R 134
I 20 1 0 0 1 0 0 8
F 138 10000008
I 04 1 0 0 1 0 0 9
F 13c 00227820
X 4
C 9 0 1 0 0
I 20 1 0 0 1 0 0 a
F 140 08000080
F 144 00228020
F 200 00228820
R 200
I 20 1 0 0 1 0 0 b
F 204 00229020
F 208 00229820
F 20c 0022a020
F 210 0022a820
F 214 0022b020
F 218 0022b820
F 21c 0022c020
F 220 0022c820
F 224 0022d020
F 228 0022d820
I 20 1 0 0 1 0 0 c
I 20 1 0 0 1 0 0 d
I 20 1 0 0 1 0 0 e
I 20 1 0 0 1 0 0 f
I 20 1 0 0 1 0 0 0
I 20 1 0 0 1 0 0 2
I 20 1 0 0 1 0 0 1
I 20 1 0 0 1 0 0 7
I 20 1 0 0 1 0 0 9
X 4
C 3 44444444 0 0 0
I 20 1 0 0 1 0 0 3
D 7 44444444
